/* rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    localparam int XLEN           = 32;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [XLEN-1:0]           rv32i_word;
    typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;
    typedef logic [63:0]               order_t;

    // all ones so the first fetch load wraps to zero
    localparam order_t ORDER_RESET = '1;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // funct3 bits read as a load or a store code
    typedef union packed {
        load_funct3_t  load;
        store_funct3_t store;
    } mem_funct3_u;

endpackage : rv32i_pkg

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import rv32i_pkg::*;

    localparam rv32i_word RESET_PC = 32'h40000000;

    typedef enum logic [1:0] {
        exe_alu_out    = 2'b00,
        exe_br_en_zext = 2'b01,
        exe_u_imm      = 2'b10
    } exe_fwd_sel_t;

    typedef enum logic {
        mar_pc_out  = 1'b0,
        mar_alu_out = 1'b1
    } mar_sel_t;

    typedef enum logic {
        mem_fwd_rdata = 1'b0,
        mem_fwd_exe   = 1'b1
    } mem_fwd_sel_t;

    typedef struct packed {
        logic         mem_read;
        logic         mem_write;
        mem_funct3_u  funct3;
        mar_sel_t     mar_sel;
        mem_fwd_sel_t mem_fwd_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic       ld_reg;
        logic [4:0] rd;
    } wb_ctrl_t;

    typedef struct packed {
        exe_fwd_sel_t exe_fwd_sel;
        mem_ctrl_t    mem;
        wb_ctrl_t     wb;
        rv32i_word    pc;
    } ctrl_word_t;

    // pc in the low bits and every other field at zero
    localparam ctrl_word_t CTRL_RESET =
        ctrl_word_t'({{($bits(ctrl_word_t) - XLEN){1'b0}}, RESET_PC});

    typedef struct packed {
        rv32i_word instr;
        rv32i_word pc;
        rv32i_word pc_next;
    } fetch_pkt_t;

    typedef struct packed {
        rv32i_word  addr;
        rv32i_word  wdata;
        byte_mask_t byte_en;
    } mem_port_t;

endpackage : pipe_pkg

`default_nettype wire

/* mem_access_align.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_access_align
    import rv32i_pkg::*;
    import pipe_pkg::*;
(
    input  ctrl_word_t ctrl_i,
    input  rv32i_word  alu_out_i,
    input  rv32i_word  rs2_i,
    output mem_port_t  port_o
);

    rv32i_word  addr_raw;
    logic [1:0] offset;
    byte_mask_t base_mask;
    logic       sub_word;

    always_comb begin
        case (ctrl_i.mem.mar_sel)
            mar_pc_out: addr_raw = ctrl_i.pc;
            default:    addr_raw = alu_out_i;
        endcase
    end

    assign offset = addr_raw[1:0]; // byte lane within the word

    always_comb begin
        base_mask = '0;
        sub_word  = 1'b0;
        if (ctrl_i.mem.mem_read) begin
            case (ctrl_i.mem.funct3.load)
                lw:       base_mask = 4'b1111;
                lh, lhu: begin
                    base_mask = 4'b0011;
                    sub_word  = 1'b1;
                end
                lb, lbu: begin
                    base_mask = 4'b0001;
                    sub_word  = 1'b1;
                end
                default:  base_mask = '0;
            endcase
        end else if (ctrl_i.mem.mem_write) begin
            case (ctrl_i.mem.funct3.store)
                sw:       base_mask = 4'b1111;
                sh: begin
                    base_mask = 4'b0011;
                    sub_word  = 1'b1;
                end
                sb: begin
                    base_mask = 4'b0001;
                    sub_word  = 1'b1;
                end
                default:  base_mask = '0;
            endcase
        end
    end

    assign port_o.byte_en = sub_word ? byte_mask_t'(base_mask << offset) : base_mask;
    assign port_o.addr    = sub_word ? {addr_raw[XLEN-1:2], 2'b00} : addr_raw;
    assign port_o.wdata   = (sub_word && ctrl_i.mem.mem_write) ?
                            rs2_i << {offset, 3'b000} : rs2_i; // move data onto its lanes

    read_write_exclusive: assert final (
        !(ctrl_i.mem.mem_read === 1'b1 && ctrl_i.mem.mem_write === 1'b1)
    );

endmodule : mem_access_align

`default_nettype wire

/* fetch_decode_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_decode_reg
    import rv32i_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_i,
    input  logic       flush_i,
    input  fetch_pkt_t pkt_i,
    output fetch_pkt_t pkt_o,
    output logic       valid_o,
    output order_t     order_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pkt_o   <= '0;
            valid_o <= 1'b0;
        end else if (flush_i) begin
            pkt_o   <= '0; // squash wrong-path fetch
            valid_o <= 1'b0;
        end else if (ld_i) begin
            pkt_o   <= pkt_i;
            valid_o <= 1'b1;
        end
    end

    // commit order steps back when the loaded fetch is squashed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            order_o <= ORDER_RESET;
        end else if (ld_i && !flush_i) begin
            order_o <= order_o + order_t'(1);
        end else if (ld_i && flush_i) begin
            order_o <= order_o - order_t'(1);
        end
    end

    flush_clears_valid: assert property (
        @(posedge clk) disable iff (rst)
        flush_i |=> !valid_o
    );

endmodule : fetch_decode_reg

`default_nettype wire

/* decode_exec_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_exec_reg
    import rv32i_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_i,
    input  ctrl_word_t ctrl_i,
    input  rv32i_word  u_imm_i,
    input  logic       valid_i,
    output ctrl_word_t ctrl_o,
    output rv32i_word  u_imm_o,
    output logic       valid_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_o  <= CTRL_RESET;
            u_imm_o <= '0;
            valid_o <= 1'b0;
        end else if (ld_i) begin
            ctrl_o  <= ctrl_i;
            u_imm_o <= u_imm_i;
            valid_o <= valid_i; // a bubble stays a bubble
        end
    end

endmodule : decode_exec_reg

`default_nettype wire

/* exec_mem_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_mem_reg
    import rv32i_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_i,
    input  logic       flush_i,
    input  logic       valid_i,
    input  ctrl_word_t ctrl_i,
    input  rv32i_word  u_imm_i,
    input  rv32i_word  alu_out_i,
    input  rv32i_word  rs2_i,
    input  logic       br_en_i,
    output rv32i_word  exe_fwd_o,
    output rv32i_word  u_imm_o,
    output logic       br_en_o,
    output logic       valid_o,
    output ctrl_word_t ctrl_o,
    output mem_port_t  port_o
);

    rv32i_word fwd_d;
    mem_port_t port_d;
    logic      mem_acc;

    always_comb begin
        case (ctrl_i.exe_fwd_sel)
            exe_alu_out:    fwd_d = alu_out_i;
            exe_br_en_zext: fwd_d = {{(XLEN-1){1'b0}}, br_en_i};
            default:        fwd_d = u_imm_i;
        endcase
    end

    mem_access_align u_mem_access_align (
        .ctrl_i    (ctrl_i),
        .alu_out_i (alu_out_i),
        .rs2_i     (rs2_i),
        .port_o    (port_d)
    );

    assign mem_acc = ctrl_i.mem.mem_read | ctrl_i.mem.mem_write;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe_fwd_o <= '0;
            u_imm_o   <= '0;
            br_en_o   <= 1'b0;
            ctrl_o    <= CTRL_RESET;
        end else if (ld_i) begin
            exe_fwd_o <= fwd_d;
            u_imm_o   <= u_imm_i;
            br_en_o   <= br_en_i;
            ctrl_o    <= ctrl_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0; // flush wins over load
        end else if (ld_i) begin
            valid_o <= valid_i;
        end
    end

    // primed here so the memory stage can start its access at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_o <= '0;
        end else if (ld_i && mem_acc) begin
            port_o <= port_d;
        end
    end

    access_has_lanes: assert property (
        @(posedge clk) disable iff (rst)
        (ld_i && mem_acc) |=> (port_o.byte_en != '0)
    );

endmodule : exec_mem_reg

`default_nettype wire

/* mem_wb_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_wb_reg
    import rv32i_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_i,
    input  logic       valid_i,
    input  ctrl_word_t ctrl_i,
    input  rv32i_word  exe_fwd_i,
    input  rv32i_word  mem_rdata_i,
    input  rv32i_word  u_imm_i,
    input  logic       br_en_i,
    output rv32i_word  mem_fwd_o,
    output rv32i_word  mem_rdata_o,
    output rv32i_word  exe_fwd_o,
    output rv32i_word  u_imm_o,
    output logic       br_en_o,
    output logic       valid_o,
    output wb_ctrl_t   wb_o
);

    rv32i_word fwd_d;

    always_comb begin
        case (ctrl_i.mem.mem_fwd_sel)
            mem_fwd_rdata: fwd_d = mem_rdata_i; // loads forward memory data
            default:       fwd_d = exe_fwd_i;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_fwd_o   <= '0;
            mem_rdata_o <= '0;
            exe_fwd_o   <= '0;
            u_imm_o     <= '0;
            br_en_o     <= 1'b0;
            valid_o     <= 1'b0;
            wb_o        <= '0;
        end else if (ld_i) begin
            mem_fwd_o   <= fwd_d;
            mem_rdata_o <= mem_rdata_i;
            exe_fwd_o   <= exe_fwd_i;
            u_imm_o     <= u_imm_i;
            br_en_o     <= br_en_i;
            valid_o     <= valid_i;
            wb_o        <= ctrl_i.wb;
        end
    end

endmodule : mem_wb_reg

`default_nettype wire

/* rv32i_stage_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module rv32i_stage_regs
    import rv32i_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ld_fd_i,
    input  logic       ld_de_i,
    input  logic       ld_em_i,
    input  logic       ld_mw_i,
    input  logic       flush_fd_i,
    input  logic       flush_em_i,
    input  fetch_pkt_t fetch_i,
    input  ctrl_word_t ctrl_i,
    input  rv32i_word  u_imm_i,
    input  rv32i_word  alu_out_i,
    input  rv32i_word  rs2_i,
    input  rv32i_word  mem_rdata_i,
    input  logic       br_en_i,
    output fetch_pkt_t fd_pkt_o,
    output order_t     order_o,
    output ctrl_word_t de_ctrl_o,
    output rv32i_word  exe_fwd_o,
    output mem_port_t  mem_port_o,
    output rv32i_word  mem_fwd_o,
    output rv32i_word  wb_data_o,
    output wb_ctrl_t   wb_o,
    output logic [3:0] valid_o
);

    rv32i_word  de_u_imm;
    ctrl_word_t em_ctrl;
    rv32i_word  em_u_imm;
    logic       em_br_en;

    fetch_decode_reg u_fetch_decode_reg (
        .clk     (clk),
        .rst     (rst),
        .ld_i    (ld_fd_i),
        .flush_i (flush_fd_i),
        .pkt_i   (fetch_i),
        .pkt_o   (fd_pkt_o),
        .valid_o (valid_o[0]),
        .order_o (order_o)
    );

    decode_exec_reg u_decode_exec_reg (
        .clk     (clk),
        .rst     (rst),
        .ld_i    (ld_de_i),
        .ctrl_i  (ctrl_i),
        .u_imm_i (u_imm_i),
        .valid_i (valid_o[0]),
        .ctrl_o  (de_ctrl_o),
        .u_imm_o (de_u_imm),
        .valid_o (valid_o[1])
    );

    exec_mem_reg u_exec_mem_reg (
        .clk       (clk),
        .rst       (rst),
        .ld_i      (ld_em_i),
        .flush_i   (flush_em_i),
        .valid_i   (valid_o[1]),
        .ctrl_i    (de_ctrl_o),
        .u_imm_i   (de_u_imm),
        .alu_out_i (alu_out_i),
        .rs2_i     (rs2_i),
        .br_en_i   (br_en_i),
        .exe_fwd_o (exe_fwd_o),
        .u_imm_o   (em_u_imm),
        .br_en_o   (em_br_en),
        .valid_o   (valid_o[2]),
        .ctrl_o    (em_ctrl),
        .port_o    (mem_port_o)
    );

    // raw load data, exe data, immediate and branch flag stay internal here
    mem_wb_reg u_mem_wb_reg (
        .clk         (clk),
        .rst         (rst),
        .ld_i        (ld_mw_i),
        .valid_i     (valid_o[2]),
        .ctrl_i      (em_ctrl),
        .exe_fwd_i   (exe_fwd_o),
        .mem_rdata_i (mem_rdata_i),
        .u_imm_i     (em_u_imm),
        .br_en_i     (em_br_en),
        .mem_fwd_o   (mem_fwd_o),
        .mem_rdata_o (),
        .exe_fwd_o   (),
        .u_imm_o     (),
        .br_en_o     (),
        .valid_o     (valid_o[3]),
        .wb_o        (wb_o)
    );

    assign wb_data_o = mem_fwd_o; // writeback value is the memory forward

endmodule : rv32i_stage_regs

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam real PERIOD     = 100.0; // ns
    localparam int  RST_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o); // release away from the active edge
        rst_o = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* tb_rv32i_stage_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv32i_stage_regs
    import rv32i_pkg::*;
    import pipe_pkg::*;
();

    // reset, fetch, exe fwd, stores, loads with pipeline
    localparam int TEST_CYCLES    = 10 + 10 + 15 + 65 + 50;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic       clk;
    logic       rst;
    logic       ld_fd, ld_de, ld_em, ld_mw;
    logic       flush_fd, flush_em;
    fetch_pkt_t fetch;
    ctrl_word_t ctrl;
    rv32i_word  u_imm, alu_out, rs2, mem_rdata;
    logic       br_en;

    fetch_pkt_t fd_pkt;
    order_t     order;
    ctrl_word_t de_ctrl;
    rv32i_word  exe_fwd;
    mem_port_t  mem_port;
    rv32i_word  mem_fwd;
    rv32i_word  wb_data;
    wb_ctrl_t   wb;
    logic [3:0] valid;

    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;
    int          cycle_count;

    tb_clock_gen u_tb_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    rv32i_stage_regs u_rv32i_stage_regs (
        .clk         (clk),
        .rst         (rst),
        .ld_fd_i     (ld_fd),
        .ld_de_i     (ld_de),
        .ld_em_i     (ld_em),
        .ld_mw_i     (ld_mw),
        .flush_fd_i  (flush_fd),
        .flush_em_i  (flush_em),
        .fetch_i     (fetch),
        .ctrl_i      (ctrl),
        .u_imm_i     (u_imm),
        .alu_out_i   (alu_out),
        .rs2_i       (rs2),
        .mem_rdata_i (mem_rdata),
        .br_en_i     (br_en),
        .fd_pkt_o    (fd_pkt),
        .order_o     (order),
        .de_ctrl_o   (de_ctrl),
        .exe_fwd_o   (exe_fwd),
        .mem_port_o  (mem_port),
        .mem_fwd_o   (mem_fwd),
        .wb_data_o   (wb_data),
        .wb_o        (wb),
        .valid_o     (valid)
    );

    task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t got, input byte_mask_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_order(input string name, input order_t got, input order_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
        end
        return out_bit;
    endfunction

    function automatic rv32i_word rand_word();
        rv32i_word w;
        w = '0;
        for (int i = 0; i < XLEN; i++) begin
            w = {w[XLEN-2:0], lfsr_bit()};
        end
        return w;
    endfunction

    // low two funct3 bits give the width for loads and stores alike
    function automatic int access_bytes(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic byte_mask_t expect_mask(input int size, input logic [1:0] off);
        byte_mask_t m;
        m = 4'b1111;
        if (size < BYTES_PER_WORD) begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                m[i] = (i >= int'(off)) && (i < int'(off) + size); // lanes past 3 fall off
            end
        end
        return m;
    endfunction

    task automatic check_access(input rv32i_word a, input int size, input rv32i_word wdata);
        rv32i_word a_exp;
        a_exp = (size < BYTES_PER_WORD) ? {a[XLEN-1:2], 2'b00} : a;
        check_word("mem_port_o.addr", mem_port.addr, a_exp);
        check_word("mem_port_o.wdata", mem_port.wdata, wdata);
        check_mask("mem_port_o.byte_en", mem_port.byte_en, expect_mask(size, a[1:0]));
    endtask

    task automatic load_decode(input ctrl_word_t c, input rv32i_word imm);
        @(posedge clk);
        ctrl  <= c;
        u_imm <= imm;
        ld_de <= 1'b1;
        @(posedge clk);
        ld_de <= 1'b0;
    endtask

    task automatic load_execute(input rv32i_word alu, input logic br, input rv32i_word src);
        @(posedge clk);
        alu_out <= alu;
        br_en   <= br;
        rs2     <= src;
        ld_em   <= 1'b1;
        @(posedge clk);
        ld_em <= 1'b0;
        @(negedge clk);
    endtask

    task automatic load_memwb(input rv32i_word rdata);
        @(posedge clk);
        mem_rdata <= rdata;
        ld_mw     <= 1'b1;
        @(posedge clk);
        ld_mw <= 1'b0;
        @(negedge clk);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            check_bit($sformatf("valid_o[%0d]", i), valid[i], 1'b0);
        end
        check_order("order_o", order, {64{1'b1}});
        check_word("mem_port_o.addr", mem_port.addr, '0);
        check_word("mem_port_o.wdata", mem_port.wdata, '0);
        check_mask("mem_port_o.byte_en", mem_port.byte_en, '0);
        check_word("de_ctrl_o.pc", de_ctrl.pc, 32'h4000_0000);
    endtask

    task automatic test_fetch_order();
        fetch_pkt_t pkt;
        for (int i = 0; i < 3; i++) begin
            pkt.instr   = rand_word();
            pkt.pc      = rand_word();
            pkt.pc_next = pkt.pc + 32'd4;
            @(posedge clk);
            fetch <= pkt;
            ld_fd <= 1'b1;
            @(posedge clk);
            ld_fd <= 1'b0;
            @(negedge clk);
            check_word("fd_pkt_o.instr", fd_pkt.instr, pkt.instr);
            check_word("fd_pkt_o.pc", fd_pkt.pc, pkt.pc);
            check_word("fd_pkt_o.pc_next", fd_pkt.pc_next, pkt.pc_next);
            check_bit("valid_o[0]", valid[0], 1'b1);
            check_order("order_o", order, order_t'(i));
        end
        @(posedge clk);
        ld_fd    <= 1'b1;
        flush_fd <= 1'b1;
        @(posedge clk);
        ld_fd    <= 1'b0;
        flush_fd <= 1'b0;
        @(negedge clk);
        check_bit("valid_o[0]", valid[0], 1'b0);
        check_word("fd_pkt_o.instr", fd_pkt.instr, '0);
        check_order("order_o", order, order_t'(1)); // squashed fetch hands its number back
    endtask

    task automatic test_exe_fwd();
        ctrl_word_t c;
        rv32i_word  imm;
        rv32i_word  alu;
        rv32i_word  expected;
        logic       br;
        for (int k = 0; k < 3; k++) begin
            c             = '0;
            c.exe_fwd_sel = exe_fwd_sel_t'(k);
            c.pc          = rand_word();
            imm           = rand_word() & 32'hffff_f000; // U-immediate fills the top 20 bits
            alu           = rand_word();
            br            = (k == 1) ? 1'b1 : lfsr_bit();
            load_decode(c, imm);
            load_execute(alu, br, rand_word());
            if (k == 0) begin
                expected = alu;
            end else if (k == 1) begin
                expected = {31'd0, br};
            end else begin
                expected = imm;
            end
            check_word("exe_fwd_o", exe_fwd, expected);
            check_word("de_ctrl_o.pc", de_ctrl.pc, c.pc);
        end
    endtask

    task automatic test_store_lanes();
        ctrl_word_t c;
        rv32i_word  a;
        rv32i_word  src;
        rv32i_word  wdata;
        int         size;
        for (int f = 0; f < 3; f++) begin
            for (int off = 0; off < 4; off++) begin
                c                  = '0;
                c.pc               = rand_word();
                c.mem.mem_write    = 1'b1;
                c.mem.funct3.store = store_funct3_t'(f);
                c.mem.mar_sel      = mar_alu_out;
                a                  = rand_word();
                a[1:0]             = off[1:0];
                src                = rand_word();
                size               = access_bytes(3'(f));
                wdata              = (size < BYTES_PER_WORD) ? src << (8 * off) : src;
                load_decode(c, rand_word());
                load_execute(a, lfsr_bit(), src);
                check_access(a, size, wdata);
            end
        end
        c.mem.mem_write = 1'b0; // plain ALU op
        load_decode(c, rand_word());
        load_execute(rand_word(), 1'b0, rand_word());
        check_access(a, size, wdata); // last store stays on the port
    endtask

    task automatic test_load_fwd();
        ctrl_word_t c;
        rv32i_word  alu;
        rv32i_word  src;
        rv32i_word  rdata;
        for (int f = 0; f < 6; f++) begin
            if (f != 3) begin
                c                 = '0;
                c.pc              = rand_word();
                c.mem.mem_read    = 1'b1;
                c.mem.funct3.load = load_funct3_t'(f);
                c.mem.mar_sel     = mar_pc_out;
                src               = rand_word();
                load_decode(c, rand_word());
                load_execute(rand_word(), 1'b0, src);
                check_access(c.pc, access_bytes(3'(f)), src); // rs2 passes unshifted
            end
        end
        for (int k = 0; k < 2; k++) begin
            c                 = '0;
            c.mem.mem_read    = (k == 0);
            c.mem.mem_fwd_sel = mem_fwd_sel_t'(k);
            c.wb.ld_reg       = 1'b1;
            c.wb.rd           = 5'(k + 7);
            alu               = rand_word();
            rdata             = rand_word();
            load_decode(c, rand_word());
            load_execute(alu, 1'b0, rand_word());
            load_memwb(rdata);
            check_word("mem_fwd_o", mem_fwd, (k == 0) ? rdata : alu);
            check_word("wb_data_o", wb_data, (k == 0) ? rdata : alu);
            check_word("wb_o.rd", rv32i_word'(wb.rd), rv32i_word'(c.wb.rd));
        end
    endtask

    task automatic test_pipeline();
        ctrl_word_t c;
        rv32i_word  alu;
        logic [3:0] expect_valid;
        c                 = '0;
        c.pc              = rand_word();
        c.mem.mem_fwd_sel = mem_fwd_exe;
        c.wb.ld_reg       = 1'b1;
        c.wb.rd           = 5'd19;
        alu               = rand_word();
        expect_valid      = 4'b0000;
        @(posedge clk);
        ld_fd <= 1'b1;
        ld_de <= 1'b1;
        ld_em <= 1'b1;
        ld_mw <= 1'b1;
        for (int e = 0; e < 4; e++) begin
            @(posedge clk);
            if (e == 0) begin
                ctrl    <= c; // decoder answers the fetched word
                alu_out <= alu;
            end
            @(negedge clk);
            expect_valid = {expect_valid[2:0], 1'b1};
            for (int i = 0; i < 4; i++) begin
                check_bit($sformatf("valid_o[%0d]", i), valid[i], expect_valid[i]);
            end
            // rd 8 is left over from the last forwarding op
            check_word("wb_o.rd", rv32i_word'(wb.rd), (e == 3) ? 32'd19 : 32'd8);
        end
        check_bit("wb_o.ld_reg", wb.ld_reg, 1'b1);
        check_word("wb_data_o", wb_data, alu);
        @(posedge clk);
        flush_em <= 1'b1;
        @(posedge clk);
        flush_em <= 1'b0;
        ld_fd    <= 1'b0;
        ld_de    <= 1'b0;
        ld_em    <= 1'b0;
        ld_mw    <= 1'b0;
        @(negedge clk);
        check_bit("valid_o[2]", valid[2], 1'b0);
        check_bit("valid_o[3]", valid[3], 1'b1);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        lfsr_state  = 32'h60aa;
        check_count = 0;
        error_count = 0;
        ld_fd       = 1'b0;
        ld_de       = 1'b0;
        ld_em       = 1'b0;
        ld_mw       = 1'b0;
        flush_fd    = 1'b0;
        flush_em    = 1'b0;
        fetch       = '0;
        ctrl        = '0;
        u_imm       = '0;
        alu_out     = '0;
        rs2         = '0;
        mem_rdata   = '0;
        br_en       = 1'b0;
        @(negedge rst);
        test_reset_state();
        test_fetch_order();
        test_exe_fwd();
        test_store_lanes();
        test_load_fwd();
        test_pipeline();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_rv32i_stage_regs

`default_nettype wire

/* rv32i_stage_regs.f */
rv32i_pkg.sv
pipe_pkg.sv
mem_access_align.sv
fetch_decode_reg.sv
decode_exec_reg.sv
exec_mem_reg.sv
mem_wb_reg.sv
rv32i_stage_regs.sv
tb_clock_gen.sv
tb_rv32i_stage_regs.sv

/* Bender.yml */
package:
  name: rv32i_stage_regs

sources:
  - rv32i_pkg.sv
  - pipe_pkg.sv
  - mem_access_align.sv
  - fetch_decode_reg.sv
  - decode_exec_reg.sv
  - exec_mem_reg.sv
  - mem_wb_reg.sv
  - rv32i_stage_regs.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_rv32i_stage_regs.sv
